//--- hdl/hydrationPkg.sv
`default_nettype none

package hydrationPkg;

  // sensor reading, raw or stabilized
  typedef logic [3:0] levelT;

  // running intake total, wraps modulo 64
  typedef logic [5:0] intakeT;

  typedef logic [3:0] bcdT;   // one decimal digit
  typedef logic [6:0] segT;   // active low, bit 0 = a, bit 6 = g

  // minutes:seconds as four BCD digits, minute tens in the top nibble
  typedef struct packed {
    bcdT minTens;
    bcdT minOnes;
    bcdT secTens;
    bcdT secOnes;
  } clockTimeT;

  // one pattern per display, same digit order as clockTimeT
  typedef struct packed {
    segT minTens;
    segT minOnes;
    segT secTens;
    segT secOnes;
  } segDisplayT;

  // time base select, 1x means hour rate
  typedef enum logic [1:0] {
    rateSecond = 2'b00,
    rateMinute = 2'b01,
    rateHour   = 2'b10
  } rateSelT;

  localparam bcdT MinTensMax      = 4'd2;   // 29:59 is the last count of a period
  localparam int  AccWidthDefault = 40;     // phase accumulator width

endpackage

`default_nettype wire

//--- hdl/tickGenerator.sv
`timescale 1ns/1ps
`default_nettype none

module tickGenerator #(
  parameter int unsigned accWidth  = hydrationPkg::AccWidthDefault,
  parameter int unsigned incSecond = 21990,
  parameter int unsigned incMinute = 1319414,
  parameter int unsigned incHour   = 79164837
) (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire hydrationPkg::rateSelT rateSel,
  output logic                       timeTick,   // strobe for the clock digits
  output logic                       sampleTick  // strobe for the level sampler
);

  typedef logic [accWidth-1:0] phaseT;

  // index 0 second, 1 minute, 2 hour
  localparam phaseT incTable [3] = '{phaseT'(incSecond), phaseT'(incMinute), phaseT'(incHour)};

  logic [2:0] rateTick;   // registered carry of each accumulator

  for (genvar r = 0; r < 3; r++) begin : genRate
    phaseT             phase;
    logic              carryReg;
    logic [accWidth:0] phaseSum;   // extra bit catches the carry out

    assign phaseSum = {1'b0, phase} + {1'b0, incTable[r]};

    always_ff @(posedge clk, posedge reset) begin
      if (reset) begin
        phase    <= '0;
        carryReg <= 1'b0;
      end else begin
        phase    <= phaseSum[accWidth-1:0];   // wraps naturally
        carryReg <= phaseSum[accWidth];       // high one cycle per overflow
      end
    end

    assign rateTick[r] = carryReg;
  end

  // pick the time base, 11 also lands on the hour rate
  always_comb begin
    case (rateSel)
      hydrationPkg::rateSecond: timeTick = rateTick[0];
      hydrationPkg::rateMinute: timeTick = rateTick[1];
      default:                  timeTick = rateTick[2];
    endcase
  end

  // sensor always sampled at the real second rate
  assign sampleTick = rateTick[0];

endmodule

`default_nettype wire

//--- hdl/clockCounter.sv
`timescale 1ns/1ps
`default_nettype none

module clockCounter (
  input  wire logic                clk,
  input  wire logic                reset,
  input  wire logic                timeTick,
  output hydrationPkg::clockTimeT  clockTime,
  output logic                     periodEnd   // high on the tick that wraps 29:59
);

  // digit 0 is seconds ones, digit 3 is minute tens
  localparam hydrationPkg::bcdT digitMax [4] = '{
    4'd9,
    4'd5,
    4'd9,
    hydrationPkg::MinTensMax
  };

  hydrationPkg::bcdT digit     [4];
  hydrationPkg::bcdT digitNext [4];
  logic [4:0]        carry;   // carry[i] enters digit i

  // ripple the tick through the chain
  always_comb begin
    carry[0] = timeTick;
    for (int i = 0; i < 4; i++) begin
      carry[i+1] = carry[i] & (digit[i] == digitMax[i]);
      if (!carry[i])
        digitNext[i] = digit[i];          // hold
      else if (digit[i] == digitMax[i])
        digitNext[i] = '0;                // roll over, pass carry on
      else
        digitNext[i] = digit[i] + 4'd1;
    end
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset)
      digit <= '{default: '0};
    else
      digit <= digitNext;
  end

  // final carry already includes timeTick
  assign periodEnd = carry[4];

  assign clockTime = '{
    minTens: digit[3],
    minOnes: digit[2],
    secTens: digit[1],
    secOnes: digit[0]
  };

endmodule

`default_nettype wire

//--- hdl/levelStabilizer.sv
`timescale 1ns/1ps
`default_nettype none

module levelStabilizer (
  input  wire logic                clk,
  input  wire logic                reset,
  input  wire logic                sampleTick,
  input  wire hydrationPkg::levelT rawLevel,
  output hydrationPkg::levelT      stableLevel
);

  hydrationPkg::levelT history [4];   // [0] is the newest sample
  logic                allSame;

  // compare the entries held before this tick's shift
  assign allSame = (history[0] == history[1]) &
                   (history[1] == history[2]) &
                   (history[2] == history[3]);

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      history <= '{default: '0};
    end else if (sampleTick) begin
      history[0] <= rawLevel;
      history[1] <= history[0];
      history[2] <= history[1];
      history[3] <= history[2];
    end
  end

  // output only moves once four samples agree, so jitter is dropped
  always_ff @(posedge clk, posedge reset) begin
    if (reset)
      stableLevel <= '0;
    else if (sampleTick && allSame)
      stableLevel <= history[3];
  end

endmodule

`default_nettype wire

//--- hdl/intakeTracker.sv
`timescale 1ns/1ps
`default_nettype none

module intakeTracker (
  input  wire logic                clk,
  input  wire logic                reset,
  input  wire hydrationPkg::levelT stableLevel,
  input  wire logic                periodEnd,
  output hydrationPkg::intakeT     intakeTotal,
  output logic                     remindRequest
);

  hydrationPkg::levelT prevLevel;   // stable level one cycle back
  hydrationPkg::levelT dropSize;
  logic                isDrop;
  logic                drank;       // some drop seen in this period

  // a fall in level is water taken, a rise is a refill
  assign isDrop   = prevLevel > stableLevel;
  assign dropSize = prevLevel - stableLevel;

  always_ff @(posedge clk, posedge reset) begin
    if (reset)
      prevLevel <= '0;
    else
      prevLevel <= stableLevel;
  end

  // total wraps modulo 64
  always_ff @(posedge clk, posedge reset) begin
    if (reset)
      intakeTotal <= '0;
    else if (isDrop)
      intakeTotal <= intakeTotal + hydrationPkg::intakeT'(dropSize);
  end

  // a drop on the rollover cycle belongs to the new period
  always_ff @(posedge clk, posedge reset) begin
    if (reset)
      drank <= 1'b0;
    else if (periodEnd)
      drank <= isDrop;
    else if (isDrop)
      drank <= 1'b1;
  end

  // period ended dry
  assign remindRequest = periodEnd & ~drank;

endmodule

`default_nettype wire

//--- hdl/reminderStretcher.sv
`timescale 1ns/1ps
`default_nettype none

module reminderStretcher #(
  parameter int unsigned holdCycles = 2**26
) (
  input  wire logic clk,
  input  wire logic reset,
  input  wire logic remindRequest,
  output logic      remind
);

  localparam int cntWidth = $clog2(holdCycles + 1);

  logic [cntWidth-1:0] holdCount;   // cycles of remind still to go

  // load on a request only when idle, so no retrigger
  always_ff @(posedge clk, posedge reset) begin
    if (reset)
      holdCount <= '0;
    else if (holdCount != '0)
      holdCount <= holdCount - 1'b1;
    else if (remindRequest)
      holdCount <= cntWidth'(holdCycles);
  end

  // high for count values holdCycles down to 1
  assign remind = holdCount != '0;

endmodule

`default_nettype wire

//--- hdl/segmentDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module segmentDecoder (
  input  wire hydrationPkg::clockTimeT clockTime,
  output hydrationPkg::segDisplayT     segments
);

  // hex digit to active low pattern, g down to a
  function automatic hydrationPkg::segT toSegments(input hydrationPkg::bcdT digit);
    case (digit)
      4'h0:    return 7'b1000000;
      4'h1:    return 7'b1111001;
      4'h2:    return 7'b0100100;
      4'h3:    return 7'b0110000;
      4'h4:    return 7'b0011001;
      4'h5:    return 7'b0010010;
      4'h6:    return 7'b0000010;
      4'h7:    return 7'b1111000;
      4'h8:    return 7'b0000000;
      4'h9:    return 7'b0011000;
      4'hA:    return 7'b0001000;   // letters never show on a BCD clock
      4'hB:    return 7'b0000011;
      4'hC:    return 7'b0100111;
      4'hD:    return 7'b0100001;
      4'hE:    return 7'b0000110;
      default: return 7'b0001110;   // F
    endcase
  endfunction

  assign segments = '{
    minTens: toSegments(clockTime.minTens),
    minOnes: toSegments(clockTime.minOnes),
    secTens: toSegments(clockTime.secTens),
    secOnes: toSegments(clockTime.secOnes)
  };

endmodule

`default_nettype wire

//--- hdl/hydrationTimer.sv
`timescale 1ns/1ps
`default_nettype none

module hydrationTimer #(
  parameter int unsigned accWidth   = hydrationPkg::AccWidthDefault,
  parameter int unsigned incSecond  = 21990,      // about 1 Hz from 50 MHz
  parameter int unsigned incMinute  = 1319414,    // 60x faster
  parameter int unsigned incHour    = 79164837,   // 3600x faster
  parameter int unsigned holdCycles = 2**26       // reminder length in clk cycles
) (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire hydrationPkg::levelT   rawLevel,
  input  wire hydrationPkg::rateSelT rateSel,
  output hydrationPkg::clockTimeT    clockTime,
  output hydrationPkg::segDisplayT   segments,
  output hydrationPkg::intakeT       intakeTotal,
  output logic                       remind
);

  logic                timeTick;
  logic                sampleTick;
  logic                periodEnd;       // 29:59 to 00:00
  logic                remindRequest;
  hydrationPkg::levelT stableLevel;

  tickGenerator #(
    .accWidth  (accWidth),
    .incSecond (incSecond),
    .incMinute (incMinute),
    .incHour   (incHour)
  ) tickGen (
    .clk        (clk),
    .reset      (reset),
    .rateSel    (rateSel),
    .timeTick   (timeTick),
    .sampleTick (sampleTick)
  );

  clockCounter clockCnt (
    .clk       (clk),
    .reset     (reset),
    .timeTick  (timeTick),
    .clockTime (clockTime),
    .periodEnd (periodEnd)
  );

  levelStabilizer levelStab (
    .clk         (clk),
    .reset       (reset),
    .sampleTick  (sampleTick),
    .rawLevel    (rawLevel),
    .stableLevel (stableLevel)
  );

  intakeTracker intake (
    .clk           (clk),
    .reset         (reset),
    .stableLevel   (stableLevel),
    .periodEnd     (periodEnd),
    .intakeTotal   (intakeTotal),
    .remindRequest (remindRequest)
  );

  reminderStretcher #(
    .holdCycles (holdCycles)
  ) stretch (
    .clk           (clk),
    .reset         (reset),
    .remindRequest (remindRequest),
    .remind        (remind)
  );

  segmentDecoder segDec (
    .clockTime (clockTime),
    .segments  (segments)
  );

endmodule

`default_nettype wire

//--- tests/hydrationModel.svh
`ifndef HYDRATION_MODEL_SVH
`define HYDRATION_MODEL_SVH

// next clock value, counted in plain seconds over a 30 minute period
function automatic hydrationPkg::clockTimeT bcdSuccessor(input hydrationPkg::clockTimeT t);
  int secs;
  hydrationPkg::clockTimeT n;
  secs = int'(t.minTens) * 600 + int'(t.minOnes) * 60 + int'(t.secTens) * 10 + int'(t.secOnes);
  secs = (secs + 1) % 1800;   // 29:59 goes back to 00:00
  n.minTens = hydrationPkg::bcdT'(secs / 600);
  n.minOnes = hydrationPkg::bcdT'((secs / 60) % 10);
  n.secTens = hydrationPkg::bcdT'((secs % 60) / 10);
  n.secOnes = hydrationPkg::bcdT'(secs % 10);
  return n;
endfunction

// lit segments gfedcba per digit, inverted for the active low display
function automatic hydrationPkg::segT digitPattern(input hydrationPkg::bcdT digit);
  logic [6:0] lit;
  case (digit)
    4'd0:    lit = 7'h3F;
    4'd1:    lit = 7'h06;
    4'd2:    lit = 7'h5B;
    4'd3:    lit = 7'h4F;
    4'd4:    lit = 7'h66;
    4'd5:    lit = 7'h6D;
    4'd6:    lit = 7'h7D;
    4'd7:    lit = 7'h07;
    4'd8:    lit = 7'h7F;
    4'd9:    lit = 7'h67;   // tail segment d stays dark
    default: lit = 7'h00;   // not a BCD digit, blank
  endcase
  return ~lit;
endfunction

function automatic hydrationPkg::segDisplayT segmentsFor(input hydrationPkg::clockTimeT t);
  hydrationPkg::segDisplayT s;
  s.minTens = digitPattern(t.minTens);
  s.minOnes = digitPattern(t.minOnes);
  s.secTens = digitPattern(t.secTens);
  s.secOnes = digitPattern(t.secOnes);
  return s;
endfunction

// fibonacci lfsr, taps 8 6 5 4
function automatic logic [7:0] lfsrStep(input logic [7:0] state);
  return {state[6:0], state[7] ^ state[5] ^ state[4] ^ state[3]};
endfunction

// a settled fall in level counts as water taken, a rise adds nothing
function automatic hydrationPkg::intakeT intakeAfterStep(input hydrationPkg::intakeT total,
                                                         input hydrationPkg::levelT fromLevel,
                                                         input hydrationPkg::levelT toLevel);
  if (toLevel >= fromLevel)
    return total;
  return hydrationPkg::intakeT'((int'(total) + int'(fromLevel) - int'(toLevel)) % 64);
endfunction

`endif

//--- tests/hydrationTb.sv
`timescale 1ns/1ps
`default_nettype none

module hydrationTb;

  localparam int HoldCycles     = 20;
  localparam int SampleCycles   = 16;     // 2**8 / 16
  localparam int HourTickCycles = 2;      // 2**8 / 128
  localparam int PeriodTicks    = 1800;   // 30 minutes of ticks
  localparam int NumRandomSteps = 12;
  localparam int StepCycles     = 14 * SampleCycles + 8;   // 13 sample waits plus alignment
  localparam int SensorCycles   = (NumRandomSteps + 2) * StepCycles;
  localparam int TimeoutCycles  = 2 * PeriodTicks * HourTickCycles + SensorCycles
                                  + 4 * HoldCycles + 100;

  logic                     clk;
  logic                     reset;
  hydrationPkg::levelT      rawLevel;
  hydrationPkg::rateSelT    rateSel;
  hydrationPkg::clockTimeT  clockTime;
  hydrationPkg::segDisplayT segments;
  hydrationPkg::intakeT     intakeTotal;
  logic                     remind;

  logic [7:0]              lfsrState     = 8'd86;
  hydrationPkg::intakeT    expIntake     = '0;     // model sum of drops
  hydrationPkg::levelT     modelLevel    = '0;     // level the stabilizer should settle on
  logic                    periodHadDrop = 1'b0;
  logic                    checking      = 1'b0;
  hydrationPkg::clockTimeT expTime       = '0;     // model clock, one BCD step per change
  int                      holdLeft      = 0;      // expected remind cycles still to come
  int                      rolloverCount = 0;
  int                      cycleCount    = 0;

  `include "hydrationModel.svh"

  hydrationTimer #(
    .accWidth   (8),
    .incSecond  (16),
    .incMinute  (64),
    .incHour    (128),
    .holdCycles (HoldCycles)
  ) dut (
    .clk         (clk),
    .reset       (reset),
    .rawLevel    (rawLevel),
    .rateSel     (rateSel),
    .clockTime   (clockTime),
    .segments    (segments),
    .intakeTotal (intakeTotal),
    .remind      (remind)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic reportFailure(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic checkTime(input hydrationPkg::clockTimeT got, input hydrationPkg::clockTimeT exp);
    if (got !== exp)
      reportFailure($sformatf("clockTime %h expected %h", got, exp));
  endtask

  task automatic checkSegments(input hydrationPkg::segDisplayT got,
                               input hydrationPkg::segDisplayT exp);
    if (got !== exp)
      reportFailure($sformatf("segments %b expected %b", got, exp));
  endtask

  task automatic checkIntake(input hydrationPkg::intakeT got, input hydrationPkg::intakeT exp,
                             input string what);
    if (got !== exp)
      reportFailure($sformatf("intakeTotal %0d expected %0d %s", got, exp, what));
  endtask

  task automatic checkRemind(input logic got, input logic exp);
    if (got !== exp)
      reportFailure($sformatf("remind %b expected %b", got, exp));
  endtask

  // one lfsr step per level bit
  task automatic nextRandomLevel(output hydrationPkg::levelT value);
    for (int i = 0; i < 4; i++) begin
      value[i]  = lfsrState[7];
      lfsrState = lfsrStep(lfsrState);
    end
  endtask

  // returns on the rising edge where the n-th sample tick is taken
  task automatic waitSamples(input int n);
    repeat (n) begin
      @(posedge clk);
      while (!dut.sampleTick) @(posedge clk);
    end
  endtask

  // settle a new level, then one glitch sample in the middle of the hold
  task automatic applyLevel(input hydrationPkg::levelT newLevel);
    hydrationPkg::levelT glitch;
    glitch = ~newLevel;
    @(posedge clk);
    rawLevel <= newLevel;
    expIntake = intakeAfterStep(expIntake, modelLevel, newLevel);
    if (newLevel < modelLevel)
      periodHadDrop = 1'b1;
    modelLevel = newLevel;
    waitSamples(6);
    rawLevel <= glitch;          // taken by the next sample tick only
    @(negedge clk);
    checkIntake(intakeTotal, expIntake, "after level settled");
    waitSamples(1);
    rawLevel <= newLevel;
    waitSamples(6);
    @(negedge clk);
    checkIntake(intakeTotal, expIntake, "after glitch");
  endtask

  // outputs sampled mid cycle against the model clock
  always @(negedge clk) begin
    if (checking) begin
      if (clockTime !== expTime) begin
        expTime = bcdSuccessor(expTime);
        checkTime(clockTime, expTime);
        if (expTime == '0) begin   // 29:59 just wrapped
          rolloverCount = rolloverCount + 1;
          holdLeft      = periodHadDrop ? 0 : HoldCycles;
          periodHadDrop = 1'b0;
        end
      end
      checkSegments(segments, segmentsFor(expTime));
      checkRemind(remind, holdLeft != 0);
      if (holdLeft != 0)
        holdLeft = holdLeft - 1;
    end
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TimeoutCycles) begin
      $display("timeout: run still going after %0d clock cycles", cycleCount);
      $display("*** TEST FAILED ***");
      $fatal(1, "run timed out");
    end
  end

  initial begin
    hydrationPkg::levelT level;
    reset    = 1'b1;
    rawLevel = '0;
    rateSel  = hydrationPkg::rateSecond;
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    @(negedge clk);   // reset state
    checkTime(clockTime, '0);
    checkIntake(intakeTotal, '0, "after reset");
    checkRemind(remind, 1'b0);
    checkSegments(segments, segmentsFor('0));
    @(posedge clk);
    checking = 1'b1;

    for (int s = 0; s < NumRandomSteps; s++) begin
      if (s == NumRandomSteps / 2) begin
        @(posedge clk);
        rateSel <= hydrationPkg::rateMinute;   // switch time base mid run
      end
      nextRandomLevel(level);
      applyLevel(level);
    end
    applyLevel(4'hF);
    applyLevel(4'h0);   // sure drop inside the first period

    @(posedge clk);
    rateSel <= hydrationPkg::rateHour;
    // first rollover follows a drink, the second a dry period
    while (rolloverCount < 2) @(posedge clk);
    repeat (HoldCycles + 10) @(posedge clk);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+tests
hdl/hydrationPkg.sv
hdl/tickGenerator.sv
hdl/clockCounter.sv
hdl/levelStabilizer.sv
hdl/intakeTracker.sv
hdl/reminderStretcher.sv
hdl/segmentDecoder.sv
hdl/hydrationTimer.sv
tests/hydrationTb.sv
